// ==== source/ooo_pkg.sv ====
// ********************
// ooo_pkg
// opcode type, pipe count and pipe indices
// shared by the completion core
// ********************
package ooo_pkg;

  // opcodes carried down the execution pipes
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,  // a + b
    OP_SUB = 3'd1,  // a - b
    OP_AND = 3'd2,  // bitwise and
    OP_XOR = 3'd3,  // bitwise xor
    OP_MUL = 3'd4   // low XLEN bits of a * b
  } fu_op_t;

  // execution pipes, one bus slot each
  localparam int NUM_FU = 2;

  // pipe indices, lower index wins the bus
  localparam int FU_ALU = 0;  // single cycle
  localparam int FU_MUL = 1;  // three cycles

  // architectural register index width
  localparam int REG_BITS = 5;  // 32 arch regs

endpackage

// ==== source/exec_pipe.sv ====
`timescale 1ns/1ps
// ********************
// exec_pipe
// fixed latency execution pipe, alu ops resolve at entry and mul at the last stage
// freezes while its bus slot is held and drops squashed items
// ********************
module exec_pipe #(
  parameter int LATENCY   = 1,
  parameter int XLEN      = 32,
  parameter int ROB_DEPTH = 8,
  parameter int PR_COUNT  = 32
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         in_valid,
  input  ooo_pkg::fu_op_t              in_op,
  input  logic [XLEN-1:0]              in_a,
  input  logic [XLEN-1:0]              in_b,
  input  logic [$clog2(PR_COUNT)-1:0]  in_tag,
  input  logic [$clog2(ROB_DEPTH)-1:0] in_rob_idx,
  input  logic [ooo_pkg::REG_BITS-1:0] in_dest,
  output logic                         in_ready,
  input  logic                         rollback_en,
  input  logic [$clog2(ROB_DEPTH)-1:0] rollback_idx,
  input  logic [$clog2(ROB_DEPTH)-1:0] rollback_span,
  output logic                         done,
  output logic [$clog2(PR_COUNT)-1:0]  tag,
  output logic [$clog2(ROB_DEPTH)-1:0] rob_idx,
  output logic [ooo_pkg::REG_BITS-1:0] dest,
  output logic [XLEN-1:0]              result,
  input  logic                         slot_free
);
  localparam int ROB_BITS = $clog2(ROB_DEPTH);
  localparam int TAG_BITS = $clog2(PR_COUNT);

  logic [LATENCY-1:0]           vld;              // stage valid bits
  logic [LATENCY-1:0]           nxt_vld;
  logic [LATENCY-1:0]           kill;             // stage younger than rollback
  logic [ROB_BITS-1:0]          age    [LATENCY]; // distance past rollback_idx
  ooo_pkg::fu_op_t              op_q   [LATENCY];
  logic [XLEN-1:0]              a_q    [LATENCY];
  logic [XLEN-1:0]              b_q    [LATENCY];
  logic [XLEN-1:0]              res_q  [LATENCY]; // alu result from entry
  logic [TAG_BITS-1:0]          tag_q  [LATENCY];
  logic [ROB_BITS-1:0]          rob_q  [LATENCY];
  logic [ooo_pkg::REG_BITS-1:0] dest_q [LATENCY];
  logic                         hold;             // output waiting on the slot

  function automatic logic [XLEN-1:0] alu(input ooo_pkg::fu_op_t op,
                                          input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
    case (op)
      ooo_pkg::OP_ADD: return a + b;
      ooo_pkg::OP_SUB: return a - b;
      ooo_pkg::OP_AND: return a & b;
      ooo_pkg::OP_XOR: return a ^ b;
      default:         return '0;  // mul resolves at the output stage
    endcase
  endfunction

  assign hold     = vld[LATENCY-1] && !slot_free;  // slot busy, freeze everything
  assign in_ready = !hold;

  always_comb begin
    for (int i = 0; i < LATENCY; i++) begin
      age[i]  = rob_q[i] - rollback_idx;  // wraps mod ROB_DEPTH
      kill[i] = rollback_en && vld[i] && (age[i] != '0) && (age[i] <= rollback_span);
    end
  end

  always_comb begin
    nxt_vld = vld & ~kill;  // frozen stages keep survivors
    if (!hold) begin
      nxt_vld[0] = in_valid;
      for (int i = 1; i < LATENCY; i++) begin
        nxt_vld[i] = vld[i-1] && !kill[i-1];  // squash on the way through
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      vld <= '0;
    end else begin
      vld <= nxt_vld;
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      op_q[0]   <= in_op;
      a_q[0]    <= in_a;
      b_q[0]    <= in_b;
      res_q[0]  <= alu(in_op, in_a, in_b);  // add/sub/and/xor done here
      tag_q[0]  <= in_tag;
      rob_q[0]  <= in_rob_idx;
      dest_q[0] <= in_dest;
      for (int i = 1; i < LATENCY; i++) begin
        op_q[i]   <= op_q[i-1];
        a_q[i]    <= a_q[i-1];
        b_q[i]    <= b_q[i-1];
        res_q[i]  <= res_q[i-1];
        tag_q[i]  <= tag_q[i-1];
        rob_q[i]  <= rob_q[i-1];
        dest_q[i] <= dest_q[i-1];
      end
    end
  end

  assign done    = vld[LATENCY-1];
  assign tag     = tag_q[LATENCY-1];
  assign rob_idx = rob_q[LATENCY-1];
  assign dest    = dest_q[LATENCY-1];
  assign result  = (op_q[LATENCY-1] == ooo_pkg::OP_MUL) ?
                   a_q[LATENCY-1] * b_q[LATENCY-1] :  // low bits of the product
                   res_q[LATENCY-1];

endmodule

// ==== source/cdb.sv ====
`timescale 1ns/1ps
// ********************
// cdb
// one result slot per pipe, rollback squash of younger slots
// lowest held index broadcasts each cycle and frees its slot
// ********************
module cdb #(
  parameter int XLEN      = 32,
  parameter int ROB_DEPTH = 8,
  parameter int PR_COUNT  = 32
) (
  input  logic                                                clock,
  input  logic                                                reset,
  input  logic [ooo_pkg::NUM_FU-1:0]                          fu_done,
  input  logic [ooo_pkg::NUM_FU-1:0][$clog2(PR_COUNT)-1:0]    fu_tag,
  input  logic [ooo_pkg::NUM_FU-1:0][$clog2(ROB_DEPTH)-1:0]   fu_rob_idx,
  input  logic [ooo_pkg::NUM_FU-1:0][ooo_pkg::REG_BITS-1:0]   fu_dest,
  input  logic [ooo_pkg::NUM_FU-1:0][XLEN-1:0]                fu_result,
  input  logic                                                rollback_en,
  input  logic [$clog2(ROB_DEPTH)-1:0]                        rollback_idx,
  input  logic [$clog2(ROB_DEPTH)-1:0]                        rollback_span,
  output logic [ooo_pkg::NUM_FU-1:0]                          slot_free,
  output logic                                                complete_en,
  output logic [$clog2(PR_COUNT)-1:0]                         complete_tag,
  output logic [$clog2(ROB_DEPTH)-1:0]                        complete_rob_idx,
  output logic [ooo_pkg::REG_BITS-1:0]                        complete_dest,
  output logic [XLEN-1:0]                                     complete_value
);
  localparam int NUM_FU   = ooo_pkg::NUM_FU;
  localparam int FU_BITS  = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;
  localparam int ROB_BITS = $clog2(ROB_DEPTH);
  localparam int TAG_BITS = $clog2(PR_COUNT);

  logic [NUM_FU-1:0]                        taken;      // slot holds a result
  logic [NUM_FU-1:0][TAG_BITS-1:0]          s_tag;
  logic [NUM_FU-1:0][ROB_BITS-1:0]          s_rob;
  logic [NUM_FU-1:0][ooo_pkg::REG_BITS-1:0] s_dest;
  logic [NUM_FU-1:0][XLEN-1:0]              s_value;
  logic [NUM_FU-1:0][ROB_BITS-1:0]          slot_age;   // held entry past rollback_idx
  logic [NUM_FU-1:0][ROB_BITS-1:0]          in_age;     // incoming entry past rollback_idx
  logic [NUM_FU-1:0]                        slot_kill;  // held entry is younger
  logic [NUM_FU-1:0]                        in_kill;    // incoming entry is younger
  logic                                     hit;        // something to broadcast
  logic [FU_BITS-1:0]                       pick;       // winning slot

  // rollback window test, same rule for held and incoming entries
  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      slot_age[i]  = s_rob[i] - rollback_idx;
      in_age[i]    = fu_rob_idx[i] - rollback_idx;
      slot_kill[i] = rollback_en && taken[i] &&
                     (slot_age[i] != '0) && (slot_age[i] <= rollback_span);
      in_kill[i]   = rollback_en && (in_age[i] != '0) && (in_age[i] <= rollback_span);
    end
  end

  // priority pick, scan down so the lowest index lands last
  always_comb begin
    hit  = 1'b0;
    pick = '0;
    for (int i = NUM_FU - 1; i >= 0; i--) begin
      if (taken[i] && !slot_kill[i]) begin
        hit  = 1'b1;
        pick = FU_BITS'(i);
      end
    end
  end

  // free when empty, broadcasting now or squashed
  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      slot_free[i] = !taken[i] || slot_kill[i] || (hit && (pick == FU_BITS'(i)));
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      taken <= '0;
    end else begin
      for (int i = 0; i < NUM_FU; i++) begin
        if (slot_free[i]) begin
          taken[i] <= fu_done[i] && !in_kill[i];  // younger arrivals dropped
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_FU; i++) begin
      if (slot_free[i] && fu_done[i]) begin
        s_tag[i]   <= fu_tag[i];
        s_rob[i]   <= fu_rob_idx[i];
        s_dest[i]  <= fu_dest[i];
        s_value[i] <= fu_result[i];
      end
    end
  end

  assign complete_en      = hit;
  assign complete_tag     = s_tag[pick];    // to regfile and wakeup
  assign complete_rob_idx = s_rob[pick];    // to reorder window
  assign complete_dest    = s_dest[pick];   // to map table
  assign complete_value   = s_value[pick];

endmodule

// ==== source/rob_window.sv ====
`timescale 1ns/1ps
// ********************
// rob_window
// hands out ROB indices, tracks completion and retires in order
// pulls the tail back on rollback
// ********************
module rob_window #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         alloc,
  output logic [$clog2(ROB_DEPTH)-1:0] alloc_idx,
  output logic                         rob_full,
  input  logic                         complete_en,
  input  logic [$clog2(ROB_DEPTH)-1:0] complete_rob_idx,
  input  logic                         rollback_en,
  input  logic [$clog2(ROB_DEPTH)-1:0] rollback_idx,
  output logic [$clog2(ROB_DEPTH)-1:0] rollback_span,
  output logic                         retire_valid,
  output logic [$clog2(ROB_DEPTH)-1:0] retire_rob_idx
);
  localparam int ROB_BITS = $clog2(ROB_DEPTH);
  localparam int CNT_BITS = ROB_BITS + 1;

  logic [ROB_BITS-1:0]  head;       // oldest entry
  logic [ROB_BITS-1:0]  tail;       // next free entry
  logic [ROB_BITS-1:0]  new_tail;   // tail after rollback recovery
  logic [CNT_BITS-1:0]  count;      // outstanding entries
  logic [CNT_BITS-1:0]  count_nxt;
  logic [ROB_DEPTH-1:0] done_bits;  // completed, waiting to retire
  logic                 retire;

  // entries strictly younger than rollback_idx
  assign rollback_span = tail - rollback_idx - 1'b1;

  // issue in a rollback cycle lands on the recovered tail
  assign new_tail  = rollback_en ? rollback_idx + 1'b1 : tail;
  assign alloc_idx = new_tail;

  assign rob_full = (count == CNT_BITS'(ROB_DEPTH));
  assign retire   = (count != '0) && done_bits[head];  // head done

  assign retire_valid   = retire;
  assign retire_rob_idx = head;

  always_comb begin
    count_nxt = count + CNT_BITS'(alloc) - CNT_BITS'(retire);
    if (rollback_en) begin
      count_nxt = count_nxt - CNT_BITS'(rollback_span);  // drop the squashed ones
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      done_bits <= '0;
    end else begin
      count <= count_nxt;
      tail  <= new_tail + ROB_BITS'(alloc);
      if (retire) begin
        head            <= head + 1'b1;
        done_bits[head] <= 1'b0;  // entry free again
      end
      if (alloc) begin
        done_bits[new_tail] <= 1'b0;  // stale bit from a squashed entry
      end
      if (complete_en) begin
        done_bits[complete_rob_idx] <= 1'b1;
      end
    end
  end

endmodule

// ==== source/phys_regfile.sv ====
`timescale 1ns/1ps
// ********************
// phys_regfile
// physical registers written by the bus broadcast
// one combinational read port, p0 stays zero
// ********************
module phys_regfile #(
  parameter int XLEN     = 32,
  parameter int PR_COUNT = 32
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        write_en,
  input  logic [$clog2(PR_COUNT)-1:0] write_tag,
  input  logic [XLEN-1:0]             write_value,
  input  logic [$clog2(PR_COUNT)-1:0] read_tag,
  output logic [XLEN-1:0]             read_value
);
  localparam int TAG_BITS = $clog2(PR_COUNT);

  logic [XLEN-1:0] regs [PR_COUNT];  // physical registers
  logic            wr_ok;            // write to a real register

  assign wr_ok = write_en && (write_tag != TAG_BITS'(0));  // p0 ignores writes

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < PR_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[write_tag] <= write_value;
    end
  end

  // new value visible the cycle after the broadcast
  assign read_value = (read_tag == TAG_BITS'(0)) ? '0 : regs[read_tag];

endmodule

// ==== source/cdb_core.sv ====
`timescale 1ns/1ps
// ********************
// cdb_core
// completion half of the core, issue into alu and mul pipes
// bus broadcast into regfile and reorder window
// ********************
module cdb_core #(
  parameter int XLEN      = 32,
  parameter int ROB_DEPTH = 8,
  parameter int PR_COUNT  = 32
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                issue_valid,
  input  logic [$clog2(ooo_pkg::NUM_FU)-1:0]  issue_fu,
  input  ooo_pkg::fu_op_t                     issue_op,
  input  logic [XLEN-1:0]                     issue_a,
  input  logic [XLEN-1:0]                     issue_b,
  input  logic [$clog2(PR_COUNT)-1:0]         issue_tag,
  input  logic [ooo_pkg::REG_BITS-1:0]        issue_dest,
  output logic                                issue_ready,
  input  logic                                rollback_en,
  input  logic [$clog2(ROB_DEPTH)-1:0]        rollback_idx,
  output logic                                complete_en,
  output logic [$clog2(PR_COUNT)-1:0]         complete_tag,
  output logic [$clog2(ROB_DEPTH)-1:0]        complete_rob_idx,
  output logic [ooo_pkg::REG_BITS-1:0]        complete_dest,
  output logic [XLEN-1:0]                     complete_value,
  output logic                                retire_valid,
  output logic [$clog2(ROB_DEPTH)-1:0]        retire_rob_idx,
  output logic                                rob_full,
  input  logic [$clog2(PR_COUNT)-1:0]         read_tag,
  output logic [XLEN-1:0]                     read_value
);
  localparam int NUM_FU   = ooo_pkg::NUM_FU;
  localparam int FU_BITS  = $clog2(NUM_FU);
  localparam int ROB_BITS = $clog2(ROB_DEPTH);
  localparam int TAG_BITS = $clog2(PR_COUNT);

  logic [NUM_FU-1:0]                        fu_valid;    // steered issue valid
  logic [NUM_FU-1:0]                        fu_ready;
  logic [NUM_FU-1:0]                        fu_done;
  logic [NUM_FU-1:0][TAG_BITS-1:0]          fu_tag;
  logic [NUM_FU-1:0][ROB_BITS-1:0]          fu_rob_idx;
  logic [NUM_FU-1:0][ooo_pkg::REG_BITS-1:0] fu_dest;
  logic [NUM_FU-1:0][XLEN-1:0]              fu_result;
  logic [NUM_FU-1:0]                        slot_free;   // bus back-pressure
  logic [ROB_BITS-1:0]                      alloc_idx;   // ROB index for the issuing op
  logic [ROB_BITS-1:0]                      rollback_span;
  logic                                     alloc;

  assign issue_ready = fu_ready[issue_fu] && !rob_full;
  assign alloc       = issue_valid && issue_ready;

  assign fu_valid[ooo_pkg::FU_ALU] = issue_valid && !rob_full &&
                                     (issue_fu == FU_BITS'(ooo_pkg::FU_ALU));
  assign fu_valid[ooo_pkg::FU_MUL] = issue_valid && !rob_full &&
                                     (issue_fu == FU_BITS'(ooo_pkg::FU_MUL));

  exec_pipe #(.LATENCY(1), .XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH), .PR_COUNT(PR_COUNT)) u_alu (
    .clock, .reset,
    .in_valid(fu_valid[ooo_pkg::FU_ALU]), .in_op(issue_op), .in_a(issue_a), .in_b(issue_b),
    .in_tag(issue_tag), .in_rob_idx(alloc_idx), .in_dest(issue_dest),
    .in_ready(fu_ready[ooo_pkg::FU_ALU]),
    .rollback_en, .rollback_idx, .rollback_span,
    .done(fu_done[ooo_pkg::FU_ALU]), .tag(fu_tag[ooo_pkg::FU_ALU]),
    .rob_idx(fu_rob_idx[ooo_pkg::FU_ALU]), .dest(fu_dest[ooo_pkg::FU_ALU]),
    .result(fu_result[ooo_pkg::FU_ALU]), .slot_free(slot_free[ooo_pkg::FU_ALU])
  );

  exec_pipe #(.LATENCY(3), .XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH), .PR_COUNT(PR_COUNT)) u_mul (
    .clock, .reset,
    .in_valid(fu_valid[ooo_pkg::FU_MUL]), .in_op(issue_op), .in_a(issue_a), .in_b(issue_b),
    .in_tag(issue_tag), .in_rob_idx(alloc_idx), .in_dest(issue_dest),
    .in_ready(fu_ready[ooo_pkg::FU_MUL]),
    .rollback_en, .rollback_idx, .rollback_span,
    .done(fu_done[ooo_pkg::FU_MUL]), .tag(fu_tag[ooo_pkg::FU_MUL]),
    .rob_idx(fu_rob_idx[ooo_pkg::FU_MUL]), .dest(fu_dest[ooo_pkg::FU_MUL]),
    .result(fu_result[ooo_pkg::FU_MUL]), .slot_free(slot_free[ooo_pkg::FU_MUL])
  );

  cdb #(.XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH), .PR_COUNT(PR_COUNT)) u_cdb (
    .clock, .reset,
    .fu_done, .fu_tag, .fu_rob_idx, .fu_dest, .fu_result,
    .rollback_en, .rollback_idx, .rollback_span,
    .slot_free,
    .complete_en, .complete_tag, .complete_rob_idx, .complete_dest, .complete_value
  );

  rob_window #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
    .clock, .reset,
    .alloc, .alloc_idx, .rob_full,
    .complete_en, .complete_rob_idx,
    .rollback_en, .rollback_idx, .rollback_span,
    .retire_valid, .retire_rob_idx
  );

  phys_regfile #(.XLEN(XLEN), .PR_COUNT(PR_COUNT)) u_prf (
    .clock, .reset,
    .write_en(complete_en), .write_tag(complete_tag), .write_value(complete_value),
    .read_tag, .read_value
  );

endmodule

// ==== tb/cdb_core_chk.sv ====
`timescale 1ns/1ps
// ********************
// cdb_core_chk
// bus, priority, retire order and reset properties
// ********************
module cdb_core_chk #(
  parameter int ROB_DEPTH = 8
) (
  input logic                                              clock,
  input logic                                              reset,
  input logic [$clog2(ooo_pkg::NUM_FU)-1:0]                issue_fu,
  input logic                                              issue_ready,
  input logic                                              rollback_en,
  input logic                                              complete_en,
  input logic [$clog2(ROB_DEPTH)-1:0]                      complete_rob_idx,
  input logic                                              retire_valid,
  input logic [$clog2(ROB_DEPTH)-1:0]                      retire_rob_idx,
  input logic                                              rob_full,
  input logic [ooo_pkg::NUM_FU-1:0]                        fu_done,
  input logic [ooo_pkg::NUM_FU-1:0]                        slot_free,
  input logic [ooo_pkg::NUM_FU-1:0][$clog2(ROB_DEPTH)-1:0] fu_rob_idx
);
  localparam int RB = $clog2(ROB_DEPTH);

  int             fails = 0;    // read by the testbench
  logic [RB-1:0]  last_ret;     // previous retired index
  logic           seen_ret;     // a retire happened since reset
  logic [ROB_DEPTH-1:0] done_seen;  // broadcast but not yet retired

  always_ff @(posedge clock) begin
    if (reset) begin
      seen_ret  <= 1'b0;
      done_seen <= '0;
    end else begin
      if (retire_valid) begin
        seen_ret                  <= 1'b1;
        last_ret                  <= retire_rob_idx;
        done_seen[retire_rob_idx] <= 1'b0;
      end
      if (complete_en) begin
        done_seen[complete_rob_idx] <= 1'b1;
      end
    end
  end

  a_reset: assert property (@(posedge clock) reset |=> !complete_en && !retire_valid && !rob_full)
    else begin
      fails++;
      $error("outputs not idle after reset");
    end
  // a held mul slot means the alu slot owns the bus
  a_busy: assert property (@(posedge clock) disable iff (reset)
    !slot_free[ooo_pkg::FU_MUL] |-> complete_en)
    else begin
      fails++;
      $error("slot held while bus idle");
    end
  a_capture: assert property (@(posedge clock) disable iff (reset)
    ((fu_done & slot_free) != '0) && !rollback_en |=> complete_en || rollback_en)
    else begin
      fails++;
      $error("captured result not broadcast next cycle");
    end
  a_prio: assert property (@(posedge clock) disable iff (reset)
    (fu_done == '1) && slot_free[ooo_pkg::FU_MUL] && !rollback_en |=>
      rollback_en || (complete_en && complete_rob_idx == $past(fu_rob_idx[ooo_pkg::FU_ALU])))
    else begin
      fails++;
      $error("alu slot lost priority");
    end
  a_order: assert property (@(posedge clock) disable iff (reset)
    retire_valid && seen_ret |-> retire_rob_idx == RB'(last_ret + 1'b1))
    else begin
      fails++;
      $error("retire skipped an index");
    end
  a_done: assert property (@(posedge clock) disable iff (reset)
    retire_valid |-> done_seen[retire_rob_idx])
    else begin
      fails++;
      $error("retired an entry that never completed");
    end
  a_full: assert property (@(posedge clock) disable iff (reset) rob_full |-> !issue_ready)
    else begin
      fails++;
      $error("issue accepted with full reorder window");
    end
  a_hold: assert property (@(posedge clock) disable iff (reset)
    fu_done[ooo_pkg::FU_MUL] && !slot_free[ooo_pkg::FU_MUL] &&
    (issue_fu == ooo_pkg::FU_MUL) |-> !issue_ready)
    else begin
      fails++;
      $error("issue ready while mul pipe held");
    end

endmodule

bind cdb_core cdb_core_chk #(.ROB_DEPTH(ROB_DEPTH)) u_chk (.*);

// ==== tb/tb_cdb_core.sv ====
`timescale 1ns/1ps
// ********************
// tb_cdb_core
// issue bursts, random stream and rollback into the completion core
// ********************
module tb_cdb_core;
  localparam int XLEN      = 32;
  localparam int ROB_DEPTH = 8;
  localparam int PR_COUNT  = 32;
  localparam int PERIOD    = 8;
  localparam int NUM_OPS   = 34;  // 9 directed plus 20 random plus 5 around rollback

  logic                clock = 1'b0;
  logic                reset = 1'b1;
  logic                issue_valid = 1'b0;
  logic [0:0]          issue_fu = '0;
  ooo_pkg::fu_op_t     issue_op = ooo_pkg::OP_ADD;
  logic [XLEN-1:0]     issue_a = '0;
  logic [XLEN-1:0]     issue_b = '0;
  logic [4:0]          issue_tag = '0;
  logic [4:0]          issue_dest = '0;
  logic                rollback_en = 1'b0;
  logic [2:0]          rollback_idx = '0;
  logic [4:0]          read_tag = '0;
  logic                issue_ready, complete_en, retire_valid, rob_full;
  logic [4:0]          complete_tag, complete_dest;
  logic [2:0]          complete_rob_idx, retire_rob_idx;
  logic [XLEN-1:0]     complete_value, read_value;

  logic                live      [PR_COUNT];  // issued and waiting for broadcast
  logic [XLEN-1:0]     live_val  [PR_COUNT];
  logic [4:0]          live_dest [PR_COUNT];  // arch dest sent with the tag
  logic [XLEN-1:0]     reg_val   [PR_COUNT];  // expected register contents
  logic [2:0]          tag_rob   [PR_COUNT];  // rob index in issue order
  int                  rob_tail = 0;
  int                  n_alive = 0;
  int                  n_ret = 0;
  int                  errors = 0;
  int unsigned         seed;

  cdb_core #(.XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH), .PR_COUNT(PR_COUNT)) DUT (.*);

  always #(PERIOD / 2) clock = ~clock;

  function automatic logic [XLEN-1:0] op_result(input ooo_pkg::fu_op_t op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    case (op)
      ooo_pkg::OP_ADD: return a + b;
      ooo_pkg::OP_SUB: return a - b;
      ooo_pkg::OP_AND: return a & b;
      ooo_pkg::OP_XOR: return a ^ b;
      default:         return a * b;  // low half of the product
    endcase
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] got);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, got);
    end
  endtask

  task automatic send_op(input int fu, input ooo_pkg::fu_op_t op, input int tag);
    logic ok;
    issue_a     = $urandom;
    issue_b     = $urandom;
    issue_fu    = fu[0];
    issue_op    = op;
    issue_tag   = tag[4:0];
    issue_dest  = 5'($urandom);
    issue_valid = 1'b1;
    live[tag]      = 1'b1;
    live_val[tag]  = op_result(op, issue_a, issue_b);
    live_dest[tag] = issue_dest;
    tag_rob[tag]   = rob_tail[2:0];
    n_alive++;
    do begin
      @(negedge clock);
      ok = issue_ready;  // sampled mid cycle
      @(posedge clock);
    end while (!ok);
    #1;
    issue_valid = 1'b0;
    rob_tail = (rob_tail + 1) % ROB_DEPTH;
  endtask

  task automatic roll_back(input logic [2:0] ridx);
    int span;
    int age;
    span = (rob_tail - ridx - 1 + 2 * ROB_DEPTH) % ROB_DEPTH;
    for (int t = 1; t < PR_COUNT; t++) begin
      age = (tag_rob[t] - ridx + ROB_DEPTH) % ROB_DEPTH;
      if (live[t] && age >= 1 && age <= span) begin
        live[t] = 1'b0;  // younger entry never broadcasts
        n_alive--;
      end
    end
    rollback_en  = 1'b1;
    rollback_idx = ridx;
    @(posedge clock);
    #1;
    rollback_en = 1'b0;
    rob_tail = (ridx + 1) % ROB_DEPTH;
  endtask

  task automatic drain();
    while (n_ret != n_alive) @(negedge clock);
    repeat (3) @(posedge clock);
    #1;
  endtask

  // bus and retire monitor
  always @(negedge clock) begin
    if (!reset && complete_en) begin
      if (!live[complete_tag]) begin
        errors++;
        $display("broadcast of tag %0d that is squashed or already done", complete_tag);
      end else begin
        check_value($sformatf("broadcast tag %0d", complete_tag),
                    live_val[complete_tag], complete_value);
        check_value($sformatf("rob index tag %0d", complete_tag),
                    XLEN'(tag_rob[complete_tag]), XLEN'(complete_rob_idx));
        check_value($sformatf("dest tag %0d", complete_tag),
                    XLEN'(live_dest[complete_tag]), XLEN'(complete_dest));
        reg_val[complete_tag] = live_val[complete_tag];
        live[complete_tag]    = 1'b0;
      end
    end
    if (!reset && retire_valid) n_ret++;
  end

  initial begin
    #(PERIOD * (NUM_OPS * 20 + 200));
    $display("timeout: %0d errors, %0d of %0d retired", errors, n_ret, n_alive);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    seed = $urandom(48193);
    for (int t = 0; t < PR_COUNT; t++) begin
      live[t]    = 1'b0;
      reg_val[t] = '0;
      tag_rob[t] = '0;
    end
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    // mul at the head and an alu stream filling the window behind it
    send_op(ooo_pkg::FU_MUL, ooo_pkg::OP_MUL, 1);
    send_op(ooo_pkg::FU_MUL, ooo_pkg::OP_MUL, 2);
    for (int i = 3; i <= 8; i++) begin
      send_op(ooo_pkg::FU_ALU, ooo_pkg::fu_op_t'($urandom % 4), i);
    end
    // eight outstanding while the alu stream keeps the head mul off the bus
    @(negedge clock);
    check_value("rob full at depth", XLEN'(1), XLEN'(rob_full));
    @(posedge clock);
    #1;
    send_op(ooo_pkg::FU_MUL, ooo_pkg::OP_MUL, 9);  // stalls on rob_full
    drain();
    for (int i = 10; i < 30; i++) begin
      if ($urandom % 2) send_op(ooo_pkg::FU_MUL, ooo_pkg::OP_MUL, i);
      else send_op(ooo_pkg::FU_ALU, ooo_pkg::fu_op_t'($urandom % 4), i);
    end
    drain();
    // p2..p4 reused by younger muls that get squashed before they land
    send_op(ooo_pkg::FU_MUL, ooo_pkg::OP_MUL, 30);
    for (int i = 2; i <= 4; i++) begin
      send_op(ooo_pkg::FU_MUL, ooo_pkg::OP_MUL, i);
    end
    roll_back(tag_rob[30]);
    send_op(ooo_pkg::FU_ALU, ooo_pkg::OP_ADD, 31);  // takes the recovered tail
    drain();
    for (int t = 1; t < PR_COUNT; t++) begin
      read_tag = t[4:0];
      @(negedge clock);
      check_value($sformatf("regfile p%0d", t), reg_val[t], read_value);
      @(posedge clock);
      #1;
    end
    if (n_ret != n_alive) begin
      errors++;
      $display("retired %0d instructions but %0d were live", n_ret, n_alive);
    end
    $display("done: %0d check errors, %0d assertion failures", errors, DUT.u_chk.fails);
    if (errors == 0 && DUT.u_chk.fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== cdb_core.f ====
source/ooo_pkg.sv
source/exec_pipe.sv
source/cdb.sv
source/rob_window.sv
source/phys_regfile.sv
source/cdb_core.sv
tb/cdb_core_chk.sv
tb/tb_cdb_core.sv
